/* list.f */
lcdPkg.sv
lcdConfigRegs.sv
lcdOpSequencer.sv
lcdBusDriver.sv
lcdTop.sv
lcdBusMonitor.sv
lcdTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= lcdTb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qF "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* lcdTb.sv */
module lcdTb;
  timeunit 1ns;
  timeprecision 100ps;
  import lcdPkg::*;

  localparam int clkPeriodNs = 40;

  logic        clk;
  logic        rst;
  logic        opStart;
  lcdOp        opCode;
  logic        busy;
  logic        done;
  logic        regWrite;
  logic [2:0]  regAddr;
  logic [15:0] regData;
  logic        csx;
  logic        dcx;
  logic        wrx;
  busByte      data;

  logic [31:0] lcgState = 32'd77304;
  logic [15:0] tickDivSet = 16'd99;
  logic [8:0]  expQ[$];
  int          doneCount = 0;
  int          errCount = 0;
  int          testCount = 0;
  int          failedTests = 0;
  int          opBase = 0;

  lcdTop lcdTop_i (
    .clk      (clk),
    .rst      (rst),
    .opStart  (opStart),
    .opCode   (opCode),
    .busy     (busy),
    .done     (done),
    .regWrite (regWrite),
    .regAddr  (regAddr),
    .regData  (regData),
    .csx      (csx),
    .dcx      (dcx),
    .wrx      (wrx),
    .data     (data)
  );

  lcdBusMonitor busMon_i (
    .csx  (csx),
    .dcx  (dcx),
    .wrx  (wrx),
    .data (data)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  always @(negedge clk) begin
    if (done === 1'b1) begin
      doneCount++;
    end
  end

  function automatic logic [15:0] randWord();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState[31:16];  // upper bits are the better ones
  endfunction

  task automatic writeReg(input logic [2:0] addr, input logic [15:0] value);
    @(posedge clk);
    #2;
    regWrite = 1'b1;
    regAddr  = addr;
    regData  = value;
    @(posedge clk);
    #2;
    regWrite = 1'b0;
  endtask

  task automatic startOp(input lcdOp op);
    @(posedge clk);
    #2;
    opStart = 1'b1;
    opCode  = op;
    @(posedge clk);
    #2;
    opStart = 1'b0;
  endtask

  task automatic waitDone(input int startCount, input int limit, input string name);
    int n;
    n = 0;
    while (doneCount == startCount && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (doneCount == startCount) begin
      $display("%s never signalled done within %0d cycles", name, limit);
      $display("Test failures found");
      $finish;
    end
  endtask

  task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got == exp) else begin
      $display("ERROR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic expectByte(input logic isData, input busByte b);
    expQ.push_back({isData, b});
  endtask

  task automatic compareLog(input int base, input string name);
    int  got;
    int  i;
    logic bad;
    got = busMon_i.byteLog.size() - base;
    bad = 1'b0;
    checkValue(got, expQ.size(), {name, " byte count"});
    // stop at the first mismatch since a clear would flood the log
    for (i = 0; i < expQ.size() && i < got && !bad; i++) begin
      assert (busMon_i.byteLog[base + i] == expQ[i]) else begin
        $display("ERROR at %0d ns: %s byte %0d is {dcx,data}=%h, expected %h",
                 $time, name, i, busMon_i.byteLog[base + i], expQ[i]);
        errCount++;
        bad = 1'b1;
      end
    end
  endtask

  task automatic runAndCheck(input lcdOp op, input int limit, input string name,
                             input int expRises, input logic retrigger);
    int doneBefore;
    int risesBefore;
    doneBefore  = doneCount;
    risesBefore = busMon_i.csxRises;
    opBase      = busMon_i.byteLog.size();
    startOp(op);
    if (retrigger) begin
      checkValue(32'(busy), 1, {name, " busy after start"});
      startOp(opPowerUp);  // must be dropped
    end
    waitDone(doneBefore, limit, name);
    repeat (10) @(posedge clk);
    #2;
    compareLog(opBase, name);
    checkValue(doneCount - doneBefore, 1, {name, " done pulses"});
    checkValue(busMon_i.csxRises - risesBefore, expRises, {name, " csx rises"});
    checkValue(32'(busy), 0, {name, " busy at end"});
  endtask

  task automatic endTest(input string name, input int errBefore);
    testCount++;
    if (errCount == errBefore) begin
      $display("PASS  %s", name);
    end else begin
      failedTests++;
      $display("FAIL  %s", name);
    end
  endtask

  task automatic testReset();
    int errBefore;
    errBefore = errCount;
    checkValue(32'(csx), 1, "csx after reset");
    checkValue(32'(wrx), 1, "wrx after reset");
    checkValue(32'(dcx), 1, "dcx after reset");
    checkValue(32'(data), 0, "data after reset");
    checkValue(32'(busy), 0, "busy after reset");
    checkValue(32'(done), 0, "done after reset");
    checkValue(busMon_i.byteLog.size(), 0, "bytes after reset");
    tickDivSet = 16'd0;  // one tick per clock
    writeReg(regTickDiv, tickDivSet);
    endTest("reset", errBefore);
  endtask

  task automatic testPowerUp();
    int      errBefore;
    realtime gap;
    realtime minGap;
    errBefore = errCount;
    expQ.delete();
    expectByte(1'b0, cmdSwReset);
    expectByte(1'b0, cmdSleepOut);
    expectByte(1'b0, cmdPixFmt);
    expectByte(1'b1, pixFmt565);
    expectByte(1'b0, cmdMadCtl);
    expectByte(1'b1, madCtlValue);
    expectByte(1'b0, cmdDispOn);
    runAndCheck(opPowerUp, 200000, "power-up", 1, 1'b0);
    if (busMon_i.timeLog.size() >= opBase + 2) begin
      gap    = busMon_i.timeLog[opBase + 1] - busMon_i.timeLog[opBase];
      minGap = real'(waitSwReset) * (real'(tickDivSet) + 1.0) * real'(clkPeriodNs);
      assert (gap >= minGap) else begin
        $display("ERROR at %0d ns: gap after reset command %0.1f ns, need %0.1f ns",
                 $time, gap, minGap);
        errCount++;
      end
    end
    endTest("power-up", errBefore);
  endtask

  task automatic testWindow(input lcdOp op);
    int          errBefore;
    logic [15:0] first;
    logic [15:0] last;
    logic        isCol;
    errBefore = errCount;
    isCol = (op == opSetColumn);
    first = randWord();
    last  = randWord();
    writeReg(isCol ? regXStart : regYStart, first);
    writeReg(isCol ? regXEnd : regYEnd, last);
    expQ.delete();
    expectByte(1'b0, isCol ? cmdColumnSet : cmdPageSet);
    expectByte(1'b1, first[15:8]);
    expectByte(1'b1, first[7:0]);
    expectByte(1'b1, last[15:8]);
    expectByte(1'b1, last[7:0]);
    runAndCheck(op, 100, isCol ? "column window" : "page window", 1, 1'b0);
    endTest($sformatf("%s %h..%h", isCol ? "column" : "page", first, last), errBefore);
  endtask

  task automatic testFill(input int count);
    int          errBefore;
    int          i;
    logic [15:0] colour;
    errBefore = errCount;
    colour = randWord();
    writeReg(regColour, colour);
    writeReg(regCountLo, count[15:0]);
    writeReg(regCountHi, {15'd0, count[16]});
    expQ.delete();
    expectByte(1'b0, cmdMemWrite);
    for (i = 0; i < count; i++) begin
      expectByte(1'b1, colour[15:8]);
      expectByte(1'b1, colour[7:0]);
    end
    runAndCheck(opFill, count * 4 + 100, "fill", 1, 1'b0);
    endTest($sformatf("fill %0d pixels of %h", count, colour), errBefore);
  endtask

  task automatic testDisplay();
    int errBefore;
    errBefore = errCount;
    expQ.delete();
    expectByte(1'b0, cmdDispOff);
    expectByte(1'b0, cmdSleepIn);
    runAndCheck(opDispOff, 40000, "display off", 1, 1'b1);  // start while busy
    endTest("display off", errBefore);
    errBefore = errCount;
    expQ.delete();
    expectByte(1'b0, cmdSleepOut);
    expectByte(1'b0, cmdDispOn);
    runAndCheck(opDispOn, 200000, "display on", 1, 1'b0);
    endTest("display on", errBefore);
  endtask

  task automatic testClear();
    int errBefore;
    int i;
    errBefore = errCount;
    expQ.delete();
    expectByte(1'b0, cmdColumnSet);
    expectByte(1'b1, 8'h00);
    expectByte(1'b1, 8'h00);
    expectByte(1'b1, 8'h00);
    expectByte(1'b1, 8'hEF);
    expectByte(1'b0, cmdPageSet);
    expectByte(1'b1, 8'h00);
    expectByte(1'b1, 8'h00);
    expectByte(1'b1, 8'h01);
    expectByte(1'b1, 8'h3F);
    expectByte(1'b0, cmdMemWrite);
    for (i = 0; i < 153600; i++) begin
      expectByte(1'b1, 8'h00);
    end
    runAndCheck(opClear, 400000, "clear", 3, 1'b0);
    endTest("clear", errBefore);
  endtask

  initial begin
    rst      = 1'b1;
    opStart  = 1'b0;
    opCode   = opPowerUp;
    regWrite = 1'b0;
    regAddr  = '0;
    regData  = '0;
    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;
    @(posedge clk);
    #2;
    testReset();
    testPowerUp();
    testWindow(opSetColumn);
    testWindow(opSetColumn);
    testWindow(opSetPage);
    testWindow(opSetPage);
    testFill(0);
    testFill(1);
    testFill(2 + int'(randWord() % 16'd200));
    testFill(2 + int'(randWord() % 16'd200));
    testDisplay();
    testClear();
    $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* lcdBusMonitor.sv */
module lcdBusMonitor (
  input logic           csx,
  input logic           dcx,
  input logic           wrx,
  input lcdPkg::busByte data
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [8:0] byteLog[$];  // {dcx, data} per latched byte
  realtime    timeLog[$];  // time of each latch
  int         csxRises = 0;

  // panel latches on the wrx rise, only while selected
  always @(posedge wrx) begin
    if (csx === 1'b0) begin
      byteLog.push_back({dcx, data});
      timeLog.push_back($realtime);
    end
  end

  always @(posedge csx) begin
    csxRises++;  // one per finished command burst
  end

endmodule

/* lcdTop.sv */
module lcdTop (
  input  logic           clk,
  input  logic           rst,
  input  logic           opStart,
  input  lcdPkg::lcdOp   opCode,
  output logic           busy,
  output logic           done,
  input  logic           regWrite,
  input  logic [2:0]     regAddr,
  input  logic [15:0]    regData,
  output logic           csx,
  output logic           dcx,
  output logic           wrx,
  output lcdPkg::busByte data
);
  import lcdPkg::*;

  lcdConfig cfg;
  lcdConfig opCfg;
  lcdOp     activeOp;
  stepIndex step;
  logic     stepValid;
  logic     waitStep;
  usCount   waitLen;
  logic     lastStep;

  lcdConfigRegs regs_i (
    .clk      (clk),
    .rst      (rst),
    .regWrite (regWrite),
    .regAddr  (regAddr),
    .regData  (regData),
    .cfg      (cfg)
  );

  lcdOpSequencer seq_i (
    .clk       (clk),
    .rst       (rst),
    .opStart   (opStart),
    .opCode    (opCode),
    .cfg       (cfg),
    .waitStep  (waitStep),
    .waitLen   (waitLen),
    .lastStep  (lastStep),
    .activeOp  (activeOp),
    .step      (step),
    .stepValid (stepValid),
    .opCfg     (opCfg),
    .busy      (busy),
    .done      (done)
  );

  lcdBusDriver bus_i (
    .clk       (clk),
    .rst       (rst),
    .activeOp  (activeOp),
    .step      (step),
    .stepValid (stepValid),
    .opCfg     (opCfg),
    .csx       (csx),
    .dcx       (dcx),
    .wrx       (wrx),
    .data      (data),
    .waitStep  (waitStep),
    .waitLen   (waitLen),
    .lastStep  (lastStep)
  );

endmodule

/* lcdBusDriver.sv */
module lcdBusDriver (
  input  logic             clk,
  input  logic             rst,
  input  lcdPkg::lcdOp     activeOp,
  input  lcdPkg::stepIndex step,
  input  logic             stepValid,
  input  lcdPkg::lcdConfig opCfg,
  output logic             csx,
  output logic             dcx,
  output logic             wrx,
  output lcdPkg::busByte   data,
  output logic             waitStep,
  output lcdPkg::usCount   waitLen,
  output logic             lastStep
);
  import lcdPkg::*;

  typedef enum logic [2:0] {
    actNone,
    actCsxHigh,
    actCsxLow,
    actWrLow,
    actWrHigh,
    actWait,
    actLast
  } actKind;

  // what one step does to the bus
  typedef struct packed {
    actKind kind;
    logic   isData;
    busByte val;
    usCount len;
  } stepAct;

  stepAct    act;
  pixelCount fillPixels;
  stepIndex  fillLast;
  stepIndex  clearLast;
  logic      nextCsx;
  logic      nextDcx;
  logic      nextWrx;
  busByte    nextData;

  function automatic stepAct makeAct(actKind kind, logic isData, busByte val, usCount len);
    stepAct a;
    a.kind   = kind;
    a.isData = isData;
    a.val    = val;
    a.len    = len;
    return a;
  endfunction

  function automatic stepAct powerUpAct(stepIndex s);
    stepAct a;
    case (s)
      0:  a = makeAct(actCsxHigh, 1'b0, '0, '0);
      1:  a = makeAct(actCsxLow, 1'b0, '0, '0);
      2:  a = makeAct(actWrLow, 1'b0, cmdSwReset, '0);
      4:  a = makeAct(actWait, 1'b0, '0, waitSwReset);
      5:  a = makeAct(actWrLow, 1'b0, cmdSleepOut, '0);
      7:  a = makeAct(actWait, 1'b0, '0, waitSleepOut);
      8:  a = makeAct(actWrLow, 1'b0, cmdPixFmt, '0);
      10: a = makeAct(actWrLow, 1'b1, pixFmt565, '0);
      12: a = makeAct(actWrLow, 1'b0, cmdMadCtl, '0);
      14: a = makeAct(actWrLow, 1'b1, madCtlValue, '0);
      16: a = makeAct(actWrLow, 1'b0, cmdDispOn, '0);
      3, 6, 9, 11, 13, 15, 17: a = makeAct(actWrHigh, 1'b0, '0, '0);
      18: a = makeAct(actLast, 1'b0, '0, '0);
      default: a = makeAct(actNone, 1'b0, '0, '0);
    endcase
    return a;
  endfunction

  // two commands, each followed by its wait
  function automatic stepAct pairAct(stepIndex s, busByte cmdA, usCount waitA,
                                     busByte cmdB, usCount waitB);
    stepAct a;
    case (s)
      0: a = makeAct(actCsxHigh, 1'b0, '0, '0);
      1: a = makeAct(actCsxLow, 1'b0, '0, '0);
      2: a = makeAct(actWrLow, 1'b0, cmdA, '0);
      4: a = makeAct(actWait, 1'b0, '0, waitA);
      5: a = makeAct(actWrLow, 1'b0, cmdB, '0);
      7: a = makeAct(actWait, 1'b0, '0, waitB);
      3, 6: a = makeAct(actWrHigh, 1'b0, '0, '0);
      8: a = makeAct(actLast, 1'b0, '0, '0);
      default: a = makeAct(actNone, 1'b0, '0, '0);
    endcase
    return a;
  endfunction

  function automatic stepAct windowAct(stepIndex rel, busByte cmd, coord winStart,
                                       coord winEnd);
    stepAct a;
    busByte val;
    logic   isData;
    isData = 1'b1;
    case (rel[3:1])  // byte index, 1 is the command
      3'd1: begin
        val    = cmd;
        isData = 1'b0;
      end
      3'd2: val = winStart[15:8];
      3'd3: val = winStart[7:0];
      3'd4: val = winEnd[15:8];
      default: val = winEnd[7:0];
    endcase
    if (rel == '0) begin
      a = makeAct(actCsxHigh, 1'b0, '0, '0);
    end else if (rel == 19'd1) begin
      a = makeAct(actCsxLow, 1'b0, '0, '0);
    end else if (rel < windowSteps) begin
      a = makeAct(rel[0] ? actWrHigh : actWrLow, isData, val, '0);
    end else if (rel == windowSteps) begin
      a = makeAct(actLast, 1'b0, '0, '0);
    end else begin
      a = makeAct(actNone, 1'b0, '0, '0);
    end
    return a;
  endfunction

  function automatic stepAct fillAct(stepIndex rel, rgb565 colour, stepIndex lastRel);
    stepAct a;
    if (rel == '0) begin
      a = makeAct(actCsxHigh, 1'b0, '0, '0);
    end else if (rel == 19'd1) begin
      a = makeAct(actCsxLow, 1'b0, '0, '0);
    end else if (rel == lastRel) begin
      a = makeAct(actLast, 1'b0, '0, '0);
    end else if (rel < 19'd4) begin
      a = makeAct(rel[0] ? actWrHigh : actWrLow, 1'b0, cmdMemWrite, '0);
    end else begin
      // rel[1] picks the low byte of the pixel
      a = makeAct(rel[0] ? actWrHigh : actWrLow, 1'b1,
                  rel[1] ? colour[7:0] : colour[15:8], '0);
    end
    return a;
  endfunction

  // oversized counts are cut to one screen
  assign fillPixels = (opCfg.fillCount > screenPixels) ? screenPixels : opCfg.fillCount;
  assign fillLast   = (stepIndex'(fillPixels) << 2) + 19'd4;
  assign clearLast  = (stepIndex'(screenPixels) << 2) + 19'd4;

  always_comb begin
    act = makeAct(actNone, 1'b0, '0, '0);
    if (stepValid) begin
      case (activeOp)
        opPowerUp:   act = powerUpAct(step);
        opDispOn:    act = pairAct(step, cmdSleepOut, waitSleepOut, cmdDispOn, waitDispOn);
        opDispOff:   act = pairAct(step, cmdDispOff, waitDispOff, cmdSleepIn, waitSleepIn);
        opSetColumn: act = windowAct(step, cmdColumnSet, opCfg.xStart, opCfg.xEnd);
        opSetPage:   act = windowAct(step, cmdPageSet, opCfg.yStart, opCfg.yEnd);
        opFill:      act = fillAct(step, opCfg.fillColour, fillLast);
        opClear: begin
          if (step < windowSteps) begin
            act = windowAct(step, cmdColumnSet, '0, screenWidth - 16'd1);
          end else if (step < (windowSteps << 1)) begin
            act = windowAct(step - windowSteps, cmdPageSet, '0, screenHeight - 16'd1);
          end else begin
            act = fillAct(step - (windowSteps << 1), '0, clearLast);
          end
        end
        default: begin
        end
      endcase
    end
  end

  always_comb begin
    nextCsx  = csx;
    nextDcx  = dcx;
    nextWrx  = wrx;
    nextData = data;
    case (act.kind)
      actCsxHigh, actLast: begin
        nextCsx = 1'b1;
        nextWrx = 1'b1;
      end
      actCsxLow: nextCsx = 1'b0;
      actWrLow: begin
        nextWrx  = 1'b0;
        nextDcx  = act.isData;
        nextData = act.val;
      end
      actWrHigh: nextWrx = 1'b1;  // panel latches here
      default: begin  // idle and wait steps keep the lines
      end
    endcase
  end

  assign waitStep = (act.kind == actWait);
  assign waitLen  = act.len;
  assign lastStep = (act.kind == actLast);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      csx  <= 1'b1;
      dcx  <= 1'b1;
      wrx  <= 1'b1;
      data <= '0;
    end else begin
      csx  <= nextCsx;
      dcx  <= nextDcx;
      wrx  <= nextWrx;
      data <= nextData;
    end
  end

  // data must be settled before the wrx rise
  dataStable: assert property (
    @(posedge clk) disable iff (rst)
    $changed(data) |-> (!wrx || csx)
  ) else $error("data changed with wrx high and csx low");

endmodule

/* lcdOpSequencer.sv */
module lcdOpSequencer (
  input  logic             clk,
  input  logic             rst,
  input  logic             opStart,
  input  lcdPkg::lcdOp     opCode,
  input  lcdPkg::lcdConfig cfg,
  input  logic             waitStep,
  input  lcdPkg::usCount   waitLen,
  input  logic             lastStep,
  output lcdPkg::lcdOp     activeOp,
  output lcdPkg::stepIndex step,
  output logic             stepValid,
  output lcdPkg::lcdConfig opCfg,
  output logic             busy,
  output logic             done
);
  import lcdPkg::*;

  typedef enum logic [1:0] {
    idle,
    run,
    hold,
    finish
  } seqState;

  seqState     state;
  usCount      ticksLeft;
  logic [15:0] prescale;
  logic        accept;

  assign accept    = (state == idle) && opStart;
  assign busy      = (state != idle);
  assign stepValid = (state == run) || (state == hold);

  // operation and its settings stay fixed until the next accept
  always_ff @(posedge clk) begin
    if (accept) begin
      activeOp <= opCode;
      opCfg    <= cfg;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= idle;
      step      <= '0;
      ticksLeft <= '0;
      prescale  <= '0;
      done      <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        idle: begin
          if (opStart) begin
            state <= run;
            step  <= '0;
          end
        end
        run: begin
          if (lastStep) begin
            state <= finish;
            step  <= '0;
          end else if (waitStep) begin
            state     <= hold;
            ticksLeft <= waitLen;
            prescale  <= opCfg.tickDiv;
          end else begin
            step <= step + 1'b1;
          end
        end
        hold: begin
          if (prescale != 16'd0) begin
            prescale <= prescale - 16'd1;
          end else begin
            prescale <= opCfg.tickDiv;  // one tick gone
            if (ticksLeft <= 17'd1) begin
              state <= run;
              step  <= step + 1'b1;
            end else begin
              ticksLeft <= ticksLeft - 17'd1;
            end
          end
        end
        default: begin  // finish, bus already shows csx high
          state <= idle;
          done  <= 1'b1;
        end
      endcase
    end
  end

  doneNotBusy: assert property (
    @(posedge clk) disable iff (rst)
    done |-> !busy
  ) else $error("done raised while busy");

  stepHeldInWait: assert property (
    @(posedge clk) disable iff (rst)
    (state == hold) |=> (step == $past(step)) || (state == run)
  ) else $error("step moved during a wait");

endmodule

/* lcdConfigRegs.sv */
module lcdConfigRegs (
  input  logic             clk,
  input  logic             rst,
  input  logic             regWrite,
  input  logic [2:0]       regAddr,
  input  logic [15:0]      regData,
  output lcdPkg::lcdConfig cfg
);
  import lcdPkg::*;

  // full-screen window out of reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cfg.xStart     <= '0;
      cfg.xEnd       <= screenWidth - 16'd1;
      cfg.yStart     <= '0;
      cfg.yEnd       <= screenHeight - 16'd1;
      cfg.fillColour <= '0;
      cfg.fillCount  <= '0;
      cfg.tickDiv    <= tickDivDefault;
    end else if (regWrite) begin
      case (regAddr)
        regXStart: begin
          cfg.xStart <= regData;
        end
        regXEnd: begin
          cfg.xEnd <= regData;
        end
        regYStart: begin
          cfg.yStart <= regData;
        end
        regYEnd: begin
          cfg.yEnd <= regData;
        end
        regColour: begin
          cfg.fillColour <= regData;
        end
        regCountLo: begin
          cfg.fillCount[15:0] <= regData;
        end
        regCountHi: begin
          cfg.fillCount[16] <= regData[0];  // only bit 0 is kept
        end
        regTickDiv: begin
          cfg.tickDiv <= regData;
        end
        default: begin
        end
      endcase
    end
  end

  // a write must name a real register
  addrInMap: assert property (
    @(posedge clk) disable iff (rst)
    regWrite |-> !$isunknown(regAddr)
  ) else $error("register write to bad address %0h", regAddr);

endmodule

/* lcdPkg.sv */
package lcdPkg;

  typedef enum logic [2:0] {
    opPowerUp,
    opDispOn,
    opDispOff,
    opSetColumn,
    opSetPage,
    opFill,
    opClear
  } lcdOp;

  typedef logic [7:0]  busByte;
  typedef logic [15:0] coord;
  typedef logic [15:0] rgb565;
  typedef logic [16:0] pixelCount;
  typedef logic [18:0] stepIndex;  // a clear runs past 307k steps
  typedef logic [16:0] usCount;

  typedef struct packed {
    coord      xStart;
    coord      xEnd;
    coord      yStart;
    coord      yEnd;
    rgb565     fillColour;
    pixelCount fillCount;
    logic [15:0] tickDiv;
  } lcdConfig;

  // panel command set
  localparam busByte cmdSwReset   = 8'h01;
  localparam busByte cmdSleepIn   = 8'h10;
  localparam busByte cmdSleepOut  = 8'h11;
  localparam busByte cmdDispOff   = 8'h28;
  localparam busByte cmdDispOn    = 8'h29;
  localparam busByte cmdColumnSet = 8'h2A;
  localparam busByte cmdPageSet   = 8'h2B;
  localparam busByte cmdMemWrite  = 8'h2C;
  localparam busByte cmdMadCtl    = 8'h36;
  localparam busByte cmdPixFmt    = 8'h3A;

  localparam busByte madCtlValue = 8'h30;
  localparam busByte pixFmt565   = 8'h55;

  // waits in microsecond ticks
  localparam usCount waitSwReset  = 17'd5000;
  localparam usCount waitSleepOut = 17'd120000;
  localparam usCount waitDispOn   = 17'd5000;
  localparam usCount waitDispOff  = 17'd10000;
  localparam usCount waitSleepIn  = 17'd10000;

  localparam coord      screenWidth  = 16'd240;
  localparam coord      screenHeight = 16'd320;
  localparam pixelCount screenPixels = 17'd76800;

  localparam logic [15:0] tickDivDefault = 16'd99;  // 1 us at 100 MHz
  localparam stepIndex    windowSteps    = 19'd12;  // csx high up to the last window byte

  localparam logic [2:0] regXStart  = 3'd0;
  localparam logic [2:0] regXEnd    = 3'd1;
  localparam logic [2:0] regYStart  = 3'd2;
  localparam logic [2:0] regYEnd    = 3'd3;
  localparam logic [2:0] regColour  = 3'd4;
  localparam logic [2:0] regCountLo = 3'd5;
  localparam logic [2:0] regCountHi = 3'd6;
  localparam logic [2:0] regTickDiv = 3'd7;

endpackage
